// File: verilog/stream_pkg.sv
package stream_pkg;

    // number of source ports
    localparam int port_count = 4;

    // width of a source index
    localparam int port_idx_width = $clog2(port_count);

    // beat payload widths
    localparam int data_width = 16;
    // user flag marks an errored beat
    localparam int user_width = 1;

    // one beat as it travels through the mux
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic [user_width-1:0] user;
    } beat_t;

endpackage

// File: verilog/stream_if.sv
interface stream_if;
    import stream_pkg::*;

    logic [data_width-1:0] data;
    logic                  last;
    logic [user_width-1:0] user;
    logic                  valid;
    logic                  ready;

    // beat producer side
    modport source (
        output data,
        output last,
        output user,
        output valid,
        input  ready
    );

    // beat consumer side
    modport sink (
        input  data,
        input  last,
        input  user,
        input  valid,
        output ready
    );

endinterface

// File: verilog/packet_arbiter.sv
module packet_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [stream_pkg::port_count-1:0]     request,
    input  logic [stream_pkg::port_count-1:0]     acknowledge,
    output logic [stream_pkg::port_count-1:0]     grant,
    output logic                                grant_valid,
    output logic [stream_pkg::port_idx_width-1:0] grant_index
);
    import stream_pkg::*;

    logic [port_count-1:0]     grant_reg;
    logic                      grant_valid_reg;
    // also the start point of the next search
    logic [port_idx_width-1:0] grant_index_reg;

    logic [port_count-1:0]     grant_next;
    logic                      grant_valid_next;
    logic [port_idx_width-1:0] grant_index_next;

    always_comb begin
        logic found;
        int   idx;

        grant_next       = grant_reg;
        grant_valid_next = grant_valid_reg;
        grant_index_next = grant_index_reg;
        found            = 1'b0;
        idx              = 0;

        // re-arbitrate when idle or when the current packet ends
        if (!grant_valid_reg || (acknowledge & grant_reg) != '0) begin
            // search upward from the source just served, wrapping
            for (int off = 1; off <= port_count; off++) begin
                idx = (int'(grant_index_reg) + off) % port_count;
                if (!found && request[idx]) begin
                    found            = 1'b1;
                    grant_index_next = port_idx_width'(idx);
                end
            end

            grant_valid_next = found;
            grant_next       = '0;
            if (found) begin
                grant_next[grant_index_next] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_reg       <= '0;
            grant_valid_reg <= 1'b0;
            // first search after reset then starts at port 0
            grant_index_reg <= port_idx_width'(port_count - 1);
        end else begin
            grant_reg       <= grant_next;
            grant_valid_reg <= grant_valid_next;
            grant_index_reg <= grant_index_next;
        end
    end

    assign grant       = grant_reg;
    assign grant_valid = grant_valid_reg;
    assign grant_index = grant_index_reg;

endmodule

// File: verilog/skid_register.sv
module skid_register (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::beat_t in_beat,
    input  logic              in_valid,
    output logic              in_ready,
    stream_if.source          out
);
    import stream_pkg::*;

    beat_t out_beat;
    logic  out_valid;
    beat_t hold_beat;
    logic  hold_valid;
    logic  in_ready_reg;

    logic  in_take;
    logic  in_ready_early;
    logic  out_valid_next;
    logic  hold_valid_next;

    logic  store_in_to_out;
    logic  store_in_to_hold;
    logic  store_hold_to_out;

    // only a beat offered while ready was high counts
    assign in_take = in_valid && in_ready_reg;

    // ready next cycle unless the holding entry would fill
    assign in_ready_early = out.ready || (!hold_valid && (!out_valid || !in_take));

    always_comb begin
        out_valid_next    = out_valid;
        hold_valid_next   = hold_valid;
        store_in_to_out   = 1'b0;
        store_in_to_hold  = 1'b0;
        store_hold_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out.ready || !out_valid) begin
                out_valid_next  = in_take;
                store_in_to_out = 1'b1;
            end else begin
                // downstream stalled, park the beat in flight
                hold_valid_next  = in_take;
                store_in_to_hold = 1'b1;
            end
        end else if (out.ready) begin
            // drain holding entry
            out_valid_next    = hold_valid;
            hold_valid_next   = 1'b0;
            store_hold_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            hold_valid   <= 1'b0;
            in_ready_reg <= 1'b0;
        end else begin
            out_valid    <= out_valid_next;
            hold_valid   <= hold_valid_next;
            in_ready_reg <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_beat <= in_beat;
        end else if (store_hold_to_out) begin
            out_beat <= hold_beat;
        end
        if (store_in_to_hold) begin
            hold_beat <= in_beat;
        end
    end

    assign in_ready  = in_ready_reg;
    assign out.data  = out_beat.data;
    assign out.last  = out_beat.last;
    assign out.user  = out_beat.user;
    assign out.valid = out_valid;

endmodule

// File: verilog/packet_mux.sv
module packet_mux (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   src [stream_pkg::port_count],
    stream_if.source dst
);
    import stream_pkg::*;

    logic [port_count-1:0]     request;
    logic [port_count-1:0]     acknowledge;
    logic [port_count-1:0]     grant;
    logic                      grant_valid;
    logic [port_idx_width-1:0] grant_index;

    logic [port_count-1:0]     src_valid;
    logic [port_count-1:0]     src_ready;
    beat_t                     src_beat [port_count];

    beat_t                     sel_beat;
    logic                      sel_valid;
    logic                      skid_ready;

    // flatten the interface array so the grant index can select
    for (genvar i = 0; i < port_count; i++) begin : g_src
        assign src_valid[i] = src[i].valid;
        assign src_beat[i]  = '{data: src[i].data, last: src[i].last, user: src[i].user};

        // only the granted source sees ready
        assign src_ready[i] = skid_ready && grant_valid && grant[i];
        assign src[i].ready = src_ready[i];

        // packet ends when the granted source's last beat transfers
        assign acknowledge[i] = src_ready[i] && src_valid[i] && src_beat[i].last;
    end

    // current owner is kept out of the next search
    assign request = src_valid & ~grant;

    assign sel_beat  = src_beat[grant_index];
    assign sel_valid = src_valid[grant_index] && grant_valid;

    packet_arbiter u_packet_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    skid_register u_skid_register (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (sel_beat),
        .in_valid (sel_valid),
        .in_ready (skid_ready),
        .out      (dst)
    );

endmodule

// File: verilog/stream_mux_top.sv
module stream_mux_top (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  logic [stream_pkg::port_count*stream_pkg::data_width-1:0] s_tdata,
    input  logic [stream_pkg::port_count-1:0]                        s_tlast,
    input  logic [stream_pkg::port_count*stream_pkg::user_width-1:0] s_tuser,
    input  logic [stream_pkg::port_count-1:0]                        s_tvalid,
    output logic [stream_pkg::port_count-1:0]                        s_tready,
    output logic [stream_pkg::data_width-1:0]                        m_tdata,
    output logic                                                     m_tlast,
    output logic [stream_pkg::user_width-1:0]                        m_tuser,
    output logic                                                     m_tvalid,
    input  logic                                                     m_tready
);
    import stream_pkg::*;

    stream_if src_if [port_count] ();
    stream_if dst_if ();

    // packed source lanes to one interface per port
    for (genvar i = 0; i < port_count; i++) begin : g_lane
        assign src_if[i].data  = s_tdata[i*data_width +: data_width];
        assign src_if[i].last  = s_tlast[i];
        assign src_if[i].user  = s_tuser[i*user_width +: user_width];
        assign src_if[i].valid = s_tvalid[i];
        assign s_tready[i]     = src_if[i].ready;
    end

    packet_mux u_packet_mux (
        .clk (clk),
        .rst (rst),
        .src (src_if),
        .dst (dst_if)
    );

    // output interface back to plain ports
    assign m_tdata      = dst_if.data;
    assign m_tlast      = dst_if.last;
    assign m_tuser      = dst_if.user;
    assign m_tvalid     = dst_if.valid;
    assign dst_if.ready = m_tready;

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: sim/stream_mux_checker.sv
module stream_mux_checker (
    input logic                              clk,
    input logic                              rst,
    input logic [stream_pkg::port_count-1:0] s_tready,
    input logic [stream_pkg::data_width-1:0] m_tdata,
    input logic                              m_tlast,
    input logic [stream_pkg::user_width-1:0] m_tuser,
    input logic                              m_tvalid,
    input logic                              m_tready
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;

    // outputs idle on the edge after any reset edge
    reset_idle: assert property (@(posedge clk) rst |=> (!m_tvalid && s_tready == '0))
        else begin
            assert_fails++;
            $error("m_tvalid or s_tready high right after a reset edge");
        end

    // a stalled output beat must not change
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser))
        else begin
            assert_fails++;
            $error("output beat changed or dropped while stalled");
        end

    // ready goes to the granted source only
    single_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(s_tready))
        else begin
            assert_fails++;
            $error("more than one source sees ready");
        end

endmodule

bind stream_mux_top stream_mux_checker u_stream_mux_checker (.*);

// File: sim/stream_mux_tb.sv
module stream_mux_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import stream_pkg::*;

    logic                             clk;
    logic                             rst;
    logic [port_count*data_width-1:0] s_tdata  = '0;
    logic [port_count-1:0]            s_tlast  = '0;
    logic [port_count*user_width-1:0] s_tuser  = '0;
    logic [port_count-1:0]            s_tvalid = '0;
    logic [port_count-1:0]            s_tready;
    logic [data_width-1:0]            m_tdata;
    logic                             m_tlast;
    logic [user_width-1:0]            m_tuser;
    logic                             m_tvalid;
    logic                             m_tready = 1'b0;

    beat_t  port_beats [port_count][$];
    beat_t  expected [$];
    int     send_pos [port_count] = '{default: 0};
    int     total_beats  = 0;
    int     out_count    = 0;
    int     cycle_count  = 0;
    int     cycle_limit  = 200;
    int     data_errors  = 0;
    int     proto_errors = 0;
    int     reset_edges  = 0;
    logic   after_reset  = 1'b0;
    integer seed         = 43;

    tb_clock_gen u_tb_clock_gen (.clk(clk), .rst(rst));

    stream_mux_top u_stream_mux_top (.*);

    task automatic load_testdata();
        int                    fd;
        int                    fields;
        int                    port;
        logic [data_width-1:0] data;
        logic                  last;
        logic [user_width-1:0] user;
        string                 line;
        fd = $fopen("sim/stream_mux_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/stream_mux_testdata.txt");
            proto_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            fields = $sscanf(line, "%d %h %d %d", port, data, last, user);
            if (fields != 4 || port < 0 || port >= port_count) begin
                $display("malformed line in the test data file was skipped");
                proto_errors++;
                continue;
            end
            port_beats[port].push_back('{data: data, last: last, user: user});
            total_beats++;
        end
        $fclose(fd);
    endtask

    // round-robin order: whole packets, next port above the one just served
    task automatic build_expected();
        int pos [port_count];
        int served;
        int pick;
        int cand;
        served = port_count - 1;
        pick = 0;
        foreach (pos[p]) pos[p] = 0;
        while (pick >= 0) begin
            pick = -1;
            for (int off = 1; off <= port_count; off++) begin
                cand = (served + off) % port_count;
                if (pick < 0 && pos[cand] < port_beats[cand].size()) pick = cand;
            end
            if (pick >= 0) begin
                do begin
                    expected.push_back(port_beats[pick][pos[pick]]);
                    pos[pick]++;
                end while (!expected[$].last && pos[pick] < port_beats[pick].size());
                served = pick;
            end
        end
    endtask

    task automatic offer_beat(input int p);
        beat_t b;
        b = port_beats[p][send_pos[p]];
        s_tdata[p*data_width +: data_width] <= b.data;
        s_tlast[p]                          <= b.last;
        s_tuser[p*user_width +: user_width] <= b.user;
        s_tvalid[p]                         <= 1'b1;
    endtask

    // source drivers and random output ready
    always @(posedge clk) begin
        if (rst) begin
            s_tvalid <= '0;
            m_tready <= 1'b0;
        end else begin
            for (int p = 0; p < port_count; p++) begin
                if (s_tvalid[p] && s_tready[p]) begin
                    send_pos[p] = send_pos[p] + 1;
                    if (send_pos[p] >= port_beats[p].size()) begin
                        s_tvalid[p] <= 1'b0;
                    end else if (!s_tlast[p] && ($random(seed) & 3) == 0) begin
                        // idle cycle inside a packet
                        s_tvalid[p] <= 1'b0;
                    end else begin
                        offer_beat(p);
                    end
                end else if (!s_tvalid[p] && send_pos[p] < port_beats[p].size()) begin
                    offer_beat(p);
                end
            end
            m_tready <= ($random(seed) & 3) != 0;
        end
    end

    // output monitor
    always @(posedge clk) begin
        beat_t exp_beat;
        cycle_count <= cycle_count + 1;
        if ((rst && reset_edges > 0) || after_reset) begin
            if (m_tvalid !== 1'b0) begin
                $display("[ERROR] m_tvalid expected 0x0 got 0x%h around reset", m_tvalid);
                proto_errors++;
            end
            if (s_tready !== '0) begin
                $display("[ERROR] s_tready expected 0x0 got 0x%h around reset", s_tready);
                proto_errors++;
            end
        end
        if (rst) reset_edges <= reset_edges + 1;
        after_reset <= rst;
        if (!rst && m_tvalid && m_tready) begin
            if (out_count >= expected.size()) begin
                $display("extra output beat 0x%h after all expected beats", m_tdata);
                proto_errors++;
            end else begin
                exp_beat = expected[out_count];
                if (m_tdata !== exp_beat.data) begin
                    $display("[ERROR] beat %0d m_tdata expected 0x%h got 0x%h",
                             out_count, exp_beat.data, m_tdata);
                    data_errors++;
                end
                if (m_tlast !== exp_beat.last) begin
                    $display("[ERROR] beat %0d m_tlast expected 0x%h got 0x%h",
                             out_count, exp_beat.last, m_tlast);
                    data_errors++;
                end
                if (m_tuser !== exp_beat.user) begin
                    $display("[ERROR] beat %0d m_tuser expected 0x%h got 0x%h",
                             out_count, exp_beat.user, m_tuser);
                    data_errors++;
                end
            end
            out_count <= out_count + 1;
        end
    end

    initial begin
        int assert_fails;
        load_testdata();
        build_expected();
        if (total_beats == 0) begin
            $display("no beats were read from the test data file");
            proto_errors++;
        end
        cycle_limit = 8 * total_beats + 200;
        while (out_count < total_beats && cycle_count < cycle_limit) @(posedge clk);
        if (out_count < total_beats) begin
            $display("timeout: only %0d of %0d beats left the mux within %0d cycles",
                     out_count, total_beats, cycle_limit);
            proto_errors++;
        end else begin
            // a few more cycles to catch repeated beats
            repeat (20) @(posedge clk);
        end
        assert_fails = u_stream_mux_top.u_stream_mux_checker.assert_fails;
        $display("beats in %0d out %0d, errors data %0d protocol %0d assertion %0d",
                 total_beats, out_count, data_errors, proto_errors, assert_fails);
        if (data_errors + proto_errors + assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/stream_pkg.sv
verilog/stream_if.sv
verilog/packet_arbiter.sv
verilog/skid_register.sv
verilog/packet_mux.sv
verilog/stream_mux_top.sv
sim/tb_clock_gen.sv
sim/stream_mux_checker.sv
sim/stream_mux_tb.sv

// File: sim/stream_mux_testdata.txt
# port data(hex) last user
# beats of one port are listed in packet order, user 1 marks an errored beat
0 0a01 0 0
0 0a02 0 1
0 0a03 1 0
1 1b01 0 0
1 1b02 1 0
2 2c01 0 0
2 2c02 0 0
2 2c03 0 1
2 2c04 1 0
3 3d01 1 1
0 0a11 1 0
1 1b11 0 0
1 1b12 1 1
3 3d11 0 0
3 3d12 1 0
0 0a21 0 0
0 0a22 1 0
